// File: source/capture_defines.svh
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// bus widths
`define CAP_DATA_W  32
`define CAP_ADDR_W  32
`define CAP_ID_W    4
`define CAP_LEN_W   8
`define CAP_BURST_W 2
`define CAP_RESP_W  2

// register word addresses with word 6 left unmapped
`define REG_CAPTURE_CTRL 32'd0
`define REG_START_ADDR   32'd1
`define REG_END_ADDR     32'd2
`define REG_FRAME_SEQ    32'd3
`define REG_NEED_FRAME   32'd4
`define REG_SAVE_NUM     32'd5
`define REG_NOTREADY     32'd7
`define REG_HEIGHT_WIDTH 32'd8
`define REG_DE_NUM       32'd9

`define BURST_FIXED 2'd0
`define BURST_INCR  2'd1

`define RESP_OKAY   2'd0
`define RESP_SLVERR 2'd2

`define REG_UNMAPPED 32'hFFFF_FFFF

`endif

// File: source/capture_pkg.sv
`include "capture_defines.svh"

package capture_pkg;

    typedef struct packed {
        logic [`CAP_ID_W-1:0]    id;
        logic [`CAP_ADDR_W-1:0]  addr;
        logic [`CAP_LEN_W-1:0]   len;
        logic [`CAP_BURST_W-1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`CAP_DATA_W-1:0] data;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`CAP_ID_W-1:0]   id;
        logic [`CAP_RESP_W-1:0] resp;
    } axi_b_t;

    // same layout as the write address phase
    typedef struct packed {
        logic [`CAP_ID_W-1:0]    id;
        logic [`CAP_ADDR_W-1:0]  addr;
        logic [`CAP_LEN_W-1:0]   len;
        logic [`CAP_BURST_W-1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`CAP_ID_W-1:0]   id;
        logic [`CAP_DATA_W-1:0] data;
        logic [`CAP_RESP_W-1:0] resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic                   capture_on;
        logic                   capture_rst;
        logic [`CAP_DATA_W-1:0] start_write_addr;
        logic [`CAP_DATA_W-1:0] end_write_addr;
        logic [`CAP_DATA_W-1:0] capture_frame_sequence;
        logic [`CAP_DATA_W-1:0] add_need_frame_num;
    } capture_cfg_t;

    typedef struct packed {
        logic [`CAP_DATA_W-1:0] frame_save_num;
        logic                   frame_notready;
        logic [`CAP_DATA_W-1:0] frame_height_width;
        logic [`CAP_DATA_W-1:0] frame_de_num;
        logic [`CAP_DATA_W-1:0] total_need_frame_num;
    } capture_status_t;

    // control word with on at bit 0 and rst at bit 8
    typedef struct packed {
        logic [22:0] pad_hi;
        logic        capture_rst;
        logic [6:0]  pad_lo;
        logic        capture_on;
    } capture_ctrl_fields_t;

    typedef union packed {
        logic [`CAP_DATA_W-1:0] raw;
        capture_ctrl_fields_t   f;
    } capture_ctrl_word_u;

endpackage

// File: source/slave_channel_fsm.sv
`timescale 1ns/1ps

module slave_channel_fsm (
    input  logic clk,
    input  logic hdmi_rstn_sync,
    input  logic aw_valid,
    output logic aw_ready,
    input  logic w_valid,
    input  logic w_last,
    output logic w_ready,
    output logic b_valid,
    input  logic b_ready,
    input  logic ar_valid,
    output logic ar_ready,
    output logic r_valid,
    input  logic r_ready,
    output logic r_last,
    output logic wr_addr_hs,
    output logic wr_beat,
    output logic wr_idle,
    output logic rd_addr_hs,
    output logic rd_beat,
    output logic rd_idle,
    input  logic rd_final_beat
);

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    wr_state_t wr_state, wr_next;
    rd_state_t rd_state, rd_next;

    // write channel runs address, data beats until last, then response
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr_addr_hs) wr_next = WR_DATA;
            WR_DATA: if (wr_beat && w_last) wr_next = WR_RESP;
            WR_RESP: if (b_valid && b_ready) wr_next = WR_IDLE;
            default: wr_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            wr_state <= WR_IDLE;
        end else begin
            wr_state <= wr_next;
        end
    end

    // read channel ends on the beat flagged last
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_addr_hs) rd_next = RD_DATA;
            RD_DATA: if (rd_beat && r_last) rd_next = RD_IDLE;
            default: rd_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            rd_state <= RD_IDLE;
        end else begin
            rd_state <= rd_next;
        end
    end

    assign wr_idle  = (wr_state == WR_IDLE);
    assign rd_idle  = (rd_state == RD_IDLE);
    assign aw_ready = hdmi_rstn_sync && wr_idle;   // held low through reset
    assign ar_ready = hdmi_rstn_sync && rd_idle;
    assign w_ready  = (wr_state == WR_DATA);
    assign b_valid  = (wr_state == WR_RESP);
    assign r_valid  = (rd_state == RD_DATA);
    assign r_last   = r_valid && rd_final_beat;

    assign wr_addr_hs = aw_valid && aw_ready;
    assign wr_beat    = w_valid && w_ready;
    assign rd_addr_hs = ar_valid && ar_ready;
    assign rd_beat    = r_valid && r_ready;

    // a new write may not open while its response is pending
    a_aw_b_excl: assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
        !(aw_ready && b_valid));

    a_r_idle: assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
        rd_state == RD_IDLE |-> !r_valid);

endmodule

// File: source/burst_addr_gen.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module burst_addr_gen (
    input  logic                   clk,
    input  logic                   hdmi_rstn_sync,
    input  logic                   addr_hs,
    input  logic                   beat,
    input  logic                   phase_idle,
    input  capture_pkg::axi_aw_t   addr_phase,
    output logic [`CAP_ADDR_W-1:0] beat_addr,
    output logic [`CAP_ID_W-1:0]   id,
    output logic                   burst_err,
    output logic                   final_beat
);

    import capture_pkg::*;

    axi_aw_t              cur;        // address phase of the open burst
    logic [`CAP_LEN_W-1:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            cur <= addr_phase;
        end
    end

    // INCR steps one word per beat while FIXED and error bursts stay put
    always_ff @(posedge clk) begin
        if (addr_hs) begin
            beat_addr <= addr_phase.addr;
        end else if (beat && cur.burst == `BURST_INCR) begin
            beat_addr <= beat_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            beat_cnt <= '0;
        end else if (phase_idle) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // wrap and reserved codes flag the whole burst
    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            burst_err <= 1'b0;
        end else if (addr_hs) begin
            burst_err <= (addr_phase.burst != `BURST_FIXED) &&
                         (addr_phase.burst != `BURST_INCR);
        end else if (phase_idle) begin
            burst_err <= 1'b0;
        end
    end

    assign id         = cur.id;
    assign final_beat = (beat_cnt == cur.len);

    a_addr_hold: assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
        beat && !addr_hs && cur.burst != `BURST_INCR |=> $stable(beat_addr));

endmodule

// File: source/capture_regs.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_regs (
    input  logic                      clk,
    input  logic                      hdmi_rstn_sync,
    input  logic                      wr_beat,
    input  logic [`CAP_ADDR_W-1:0]    wr_addr,
    input  logic [`CAP_DATA_W-1:0]    wr_data,
    output capture_pkg::capture_cfg_t cfg,
    output logic                      need_frame_add
);

    import capture_pkg::*;

    capture_ctrl_word_u ctrl_wr;
    logic               nf_hit;

    assign ctrl_wr.raw = wr_data;
    assign nf_hit      = wr_beat && (wr_addr == `REG_NEED_FRAME);

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            cfg <= '0;
        end else if (wr_beat) begin
            case (wr_addr)
                `REG_CAPTURE_CTRL: begin
                    cfg.capture_on  <= ctrl_wr.f.capture_on;
                    cfg.capture_rst <= ctrl_wr.f.capture_rst;
                end
                `REG_START_ADDR: cfg.start_write_addr       <= wr_data;
                `REG_END_ADDR:   cfg.end_write_addr         <= wr_data;
                `REG_FRAME_SEQ:  cfg.capture_frame_sequence <= wr_data;
                `REG_NEED_FRAME: cfg.add_need_frame_num     <= wr_data;
                // status words and holes take no writes
                default: ;
            endcase
        end
    end

    // single clk pulse per beat to the frame count word
    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            need_frame_add <= 1'b0;
        end else begin
            need_frame_add <= nf_hit;
        end
    end

    a_nf_pulse: assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
        need_frame_add && $past(need_frame_add) |-> $past(nf_hit, 1) && $past(nf_hit, 2));

endmodule

// File: source/reg_read_mux.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module reg_read_mux (
    input  logic [`CAP_ADDR_W-1:0]       rd_addr,
    input  capture_pkg::capture_cfg_t    cfg,
    input  capture_pkg::capture_status_t status,
    output logic [`CAP_DATA_W-1:0]       rd_data
);

    import capture_pkg::*;

    capture_ctrl_word_u ctrl_rd;

    // pack control bits back into their word positions
    always_comb begin
        ctrl_rd               = '0;
        ctrl_rd.f.capture_on  = cfg.capture_on;
        ctrl_rd.f.capture_rst = cfg.capture_rst;
    end

    always_comb begin
        case (rd_addr)
            `REG_CAPTURE_CTRL: rd_data = ctrl_rd.raw;
            `REG_START_ADDR:   rd_data = cfg.start_write_addr;
            `REG_END_ADDR:     rd_data = cfg.end_write_addr;
            `REG_FRAME_SEQ:    rd_data = cfg.capture_frame_sequence;
            `REG_NEED_FRAME:   rd_data = status.total_need_frame_num;  // running total
            `REG_SAVE_NUM:     rd_data = status.frame_save_num;
            `REG_NOTREADY:     rd_data = {{(`CAP_DATA_W-1){1'b0}}, status.frame_notready};
            `REG_HEIGHT_WIDTH: rd_data = status.frame_height_width;
            `REG_DE_NUM:       rd_data = status.frame_de_num;
            default:           rd_data = `REG_UNMAPPED;
        endcase
    end

endmodule

// File: source/capture_ctrl_slave.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module capture_ctrl_slave (
    input  logic                        clk,
    input  logic                        hdmi_rstn_sync,
    input  capture_pkg::axi_aw_t        aw,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  capture_pkg::axi_w_t         w,
    input  logic                        w_valid,
    output logic                        w_ready,
    output capture_pkg::axi_b_t         b,
    output logic                        b_valid,
    input  logic                        b_ready,
    input  capture_pkg::axi_ar_t        ar,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    output capture_pkg::axi_r_t         r,
    output logic                        r_valid,
    input  logic                        r_ready,
    input  capture_pkg::capture_status_t status,
    output capture_pkg::capture_cfg_t   cfg,
    output logic                        need_frame_add
);

    logic                   wr_addr_hs, wr_beat, wr_idle;
    logic                   rd_addr_hs, rd_beat, rd_idle;
    logic [`CAP_ADDR_W-1:0] wr_beat_addr, rd_beat_addr;
    logic [`CAP_ID_W-1:0]   wr_id, rd_id;
    logic                   wr_err, rd_err;
    logic                   rd_final_beat;
    logic                   r_last;
    logic [`CAP_DATA_W-1:0] rd_data;

    slave_channel_fsm u_fsm (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w_valid        (w_valid),
        .w_last         (w.last),
        .w_ready        (w_ready),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .r_last         (r_last),
        .wr_addr_hs     (wr_addr_hs),
        .wr_beat        (wr_beat),
        .wr_idle        (wr_idle),
        .rd_addr_hs     (rd_addr_hs),
        .rd_beat        (rd_beat),
        .rd_idle        (rd_idle),
        .rd_final_beat  (rd_final_beat)
    );

    burst_addr_gen u_wr_burst (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .addr_hs        (wr_addr_hs),
        .beat           (wr_beat),
        .phase_idle     (wr_idle),
        .addr_phase     (aw),
        .beat_addr      (wr_beat_addr),
        .id             (wr_id),
        .burst_err      (wr_err),
        .final_beat     ()   // write end comes from w.last
    );

    burst_addr_gen u_rd_burst (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .addr_hs        (rd_addr_hs),
        .beat           (rd_beat),
        .phase_idle     (rd_idle),
        .addr_phase     (ar),
        .beat_addr      (rd_beat_addr),
        .id             (rd_id),
        .burst_err      (rd_err),
        .final_beat     (rd_final_beat)
    );

    capture_regs u_regs (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .wr_beat        (wr_beat),
        .wr_addr        (wr_beat_addr),
        .wr_data        (w.data),
        .cfg            (cfg),
        .need_frame_add (need_frame_add)
    );

    reg_read_mux u_rd_mux (
        .rd_addr (rd_beat_addr),
        .cfg     (cfg),
        .status  (status),
        .rd_data (rd_data)
    );

    assign b = '{id: wr_id, resp: wr_err ? `RESP_SLVERR : `RESP_OKAY};
    assign r = '{id: rd_id, data: rd_data, resp: rd_err ? `RESP_SLVERR : `RESP_OKAY,
                 last: r_last};

endmodule

// File: verif/tb_capture_ctrl_slave.sv
`timescale 1ns/1ps
`include "capture_defines.svh"

module tb_capture_ctrl_slave;

    import capture_pkg::*;

    logic            clk;
    logic            hdmi_rstn_sync;
    axi_aw_t         aw;
    logic            aw_valid, aw_ready;
    axi_w_t          w;
    logic            w_valid, w_ready;
    axi_b_t          b;
    logic            b_valid, b_ready;
    axi_ar_t         ar;
    logic            ar_valid, ar_ready;
    axi_r_t          r;
    logic            r_valid, r_ready;
    capture_status_t status;
    capture_cfg_t    cfg;
    logic            need_frame_add;

    logic                   m_on, m_rst;   // register model
    logic [`CAP_DATA_W-1:0] m_start, m_end, m_seq, m_need;

    logic [`CAP_DATA_W-1:0] wdata [0:15];
    logic [`CAP_ADDR_W-1:0] cur_w_addr;    // address of the beat on w
    logic [31:0]            seed;
    string                  test_name;
    int                     total_beats;
    int                     cycle_cnt;
    int                     nf_pulses;
    int                     nf_before;
    logic                   nf_expect;

    logic [`CAP_ADDR_W-1:0] exp_r_addr [$];
    logic [`CAP_ID_W-1:0]   exp_r_id [$];
    logic [`CAP_RESP_W-1:0] exp_r_resp [$];
    logic                   exp_r_last [$];
    logic [`CAP_ID_W-1:0]   exp_b_id [$];
    logic [`CAP_RESP_W-1:0] exp_b_resp [$];

    capture_ctrl_slave uut (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r              (r),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .status         (status),
        .cfg            (cfg),
        .need_frame_add (need_frame_add)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [`CAP_RESP_W-1:0] burst_resp(input logic [`CAP_BURST_W-1:0] burst);
        if (burst == `BURST_FIXED || burst == `BURST_INCR) begin
            return `RESP_OKAY;
        end
        return `RESP_SLVERR;
    endfunction

    // expected read data for a word address
    function automatic logic [31:0] ref_read(input logic [`CAP_ADDR_W-1:0] addr);
        case (addr)
            `REG_CAPTURE_CTRL: return {23'd0, m_rst, 7'd0, m_on};
            `REG_START_ADDR:   return m_start;
            `REG_END_ADDR:     return m_end;
            `REG_FRAME_SEQ:    return m_seq;
            `REG_NEED_FRAME:   return status.total_need_frame_num;
            `REG_SAVE_NUM:     return status.frame_save_num;
            `REG_NOTREADY:     return {31'd0, status.frame_notready};
            `REG_HEIGHT_WIDTH: return status.frame_height_width;
            `REG_DE_NUM:       return status.frame_de_num;
            default:           return `REG_UNMAPPED;
        endcase
    endfunction

    task automatic update_model(input logic [`CAP_ADDR_W-1:0] addr, input logic [31:0] data);
        case (addr)
            `REG_CAPTURE_CTRL: begin
                m_on  = data[0];
                m_rst = data[8];
            end
            `REG_START_ADDR: m_start = data;
            `REG_END_ADDR:   m_end = data;
            `REG_FRAME_SEQ:  m_seq = data;
            `REG_NEED_FRAME: m_need = data;
            default: ;
        endcase
    endtask

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_cfg();
        check_value("cfg.capture_on", {31'd0, m_on}, {31'd0, cfg.capture_on});
        check_value("cfg.capture_rst", {31'd0, m_rst}, {31'd0, cfg.capture_rst});
        check_value("cfg.start_write_addr", m_start, cfg.start_write_addr);
        check_value("cfg.end_write_addr", m_end, cfg.end_write_addr);
        check_value("cfg.capture_frame_sequence", m_seq, cfg.capture_frame_sequence);
        check_value("cfg.add_need_frame_num", m_need, cfg.add_need_frame_num);
    endtask

    task automatic write_burst(input logic [`CAP_ID_W-1:0] txn_id,
                               input logic [`CAP_ADDR_W-1:0] addr,
                               input logic [`CAP_LEN_W-1:0] len,
                               input logic [`CAP_BURST_W-1:0] burst);
        logic [`CAP_ADDR_W-1:0] a;
        logic [31:0]            rnd;
        logic                   done;
        a = addr;
        total_beats += len + 3;
        exp_b_id.push_back(txn_id);
        exp_b_resp.push_back(burst_resp(burst));
        @(negedge clk);
        aw.id = txn_id;
        aw.addr = addr;
        aw.len = len;
        aw.burst = burst;
        aw_valid = 1'b1;
        done = 1'b0;
        while (!done) begin
            #1;
            done = aw_ready;
            @(negedge clk);
        end
        aw_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            w.data = wdata[i];
            w.last = (i == len);
            w_valid = 1'b1;
            cur_w_addr = a;
            done = 1'b0;
            while (!done) begin
                #1;
                done = w_ready;
                @(negedge clk);
            end
            update_model(a, wdata[i]);
            if (burst == `BURST_INCR) a = a + 1'b1;   // other codes hold the address
        end
        w_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            rnd = next_random();
            b_ready = rnd[16];
            #1;
            done = b_valid && b_ready;
            @(negedge clk);
        end
        b_ready = 1'b0;
    endtask

    task automatic read_burst(input logic [`CAP_ID_W-1:0] txn_id,
                              input logic [`CAP_ADDR_W-1:0] addr,
                              input logic [`CAP_LEN_W-1:0] len,
                              input logic [`CAP_BURST_W-1:0] burst);
        logic [`CAP_ADDR_W-1:0] a;
        logic [31:0]            rnd;
        logic                   done;
        a = addr;
        total_beats += len + 2;
        for (int i = 0; i <= len; i++) begin
            exp_r_addr.push_back(a);
            exp_r_id.push_back(txn_id);
            exp_r_resp.push_back(burst_resp(burst));
            exp_r_last.push_back(i == len);
            if (burst == `BURST_INCR) a = a + 1'b1;
        end
        @(negedge clk);
        ar.id = txn_id;
        ar.addr = addr;
        ar.len = len;
        ar.burst = burst;
        ar_valid = 1'b1;
        done = 1'b0;
        while (!done) begin
            #1;
            done = ar_ready;
            @(negedge clk);
        end
        ar_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            done = 1'b0;
            while (!done) begin
                rnd = next_random();
                r_ready = rnd[16];   // random back-pressure
                #1;
                done = r_valid && r_ready;
                @(negedge clk);
            end
        end
        r_ready = 1'b0;
    endtask

    task automatic fill_wdata(input int n);
        for (int i = 0; i < n; i++) begin
            wdata[i] = next_random();
        end
    endtask

    // sample mid low phase, well clear of both edges
    always @(negedge clk) begin
        #1;
        check_value("need_frame_add", {31'd0, nf_expect}, {31'd0, need_frame_add});
        if (need_frame_add) nf_pulses++;
        nf_expect = w_valid && w_ready && (cur_w_addr == `REG_NEED_FRAME);
        if (r_valid && r_ready) begin
            if (exp_r_addr.size() == 0) begin
                $display("read beat arrived with no read burst outstanding");
                stop_with_failure();
            end
            check_value("r.data", ref_read(exp_r_addr.pop_front()), r.data);
            check_value("r.id", {28'd0, exp_r_id.pop_front()}, {28'd0, r.id});
            check_value("r.resp", {30'd0, exp_r_resp.pop_front()}, {30'd0, r.resp});
            check_value("r.last", {31'd0, exp_r_last.pop_front()}, {31'd0, r.last});
        end
        if (b_valid && b_ready) begin
            if (exp_b_id.size() == 0) begin
                $display("write response arrived with no write burst outstanding");
                stop_with_failure();
            end
            check_value("b.id", {28'd0, exp_b_id.pop_front()}, {28'd0, b.id});
            check_value("b.resp", {30'd0, exp_b_resp.pop_front()}, {30'd0, b.resp});
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 20 * total_beats + 200) begin
            $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
            stop_with_failure();
        end
    end

    initial begin
        seed = 32'hbcfc;
        hdmi_rstn_sync = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        status = '0;
        {m_on, m_rst, m_start, m_end, m_seq, m_need} = '0;
        total_beats = 0;
        cycle_cnt = 0;
        nf_pulses = 0;
        nf_expect = 1'b0;
        test_name = "reset";
        repeat (3) @(negedge clk);
        check_value("ready/valid in reset", 32'd0,
                    {26'd0, aw_ready, ar_ready, w_ready, b_valid, r_valid, need_frame_add});
        hdmi_rstn_sync = 1'b1;
        #1;
        check_value("aw_ready/ar_ready after reset", 32'd3, {30'd0, aw_ready, ar_ready});
        check_cfg();

        test_name = "reset_values";
        read_burst(4'h1, 32'd0, 8'd9, `BURST_INCR);   // covers hole at 6
        read_burst(4'h2, 32'd10, 8'd0, `BURST_INCR);
        read_burst(4'h3, 32'd200, 8'd0, `BURST_FIXED);

        test_name = "incr_burst";
        fill_wdata(4);
        write_burst(4'h5, `REG_START_ADDR, 8'd3, `BURST_INCR);
        check_cfg();
        read_burst(4'ha, `REG_START_ADDR, 8'd3, `BURST_INCR);

        test_name = "fixed_ctrl";
        fill_wdata(3);
        wdata[1] = (wdata[1] & ~32'h0000_0001) | 32'h0000_0100;   // on low, rst high
        wdata[2] = (wdata[2] | 32'h0000_0001) & ~32'h0000_0100;   // on high, rst low
        write_burst(4'h3, `REG_CAPTURE_CTRL, 8'd2, `BURST_FIXED);
        check_cfg();
        read_burst(4'h7, `REG_CAPTURE_CTRL, 8'd1, `BURST_FIXED);

        test_name = "need_frame";
        fill_wdata(1);
        nf_before = nf_pulses;
        write_burst(4'h9, `REG_NEED_FRAME, 8'd0, `BURST_INCR);
        check_value("need_frame_add pulse count", nf_before + 1, nf_pulses);
        check_cfg();

        test_name = "wrap_slverr";
        fill_wdata(2);
        write_burst(4'hc, `REG_END_ADDR, 8'd1, 2'd2);
        check_cfg();
        read_burst(4'hd, `REG_FRAME_SEQ, 8'd2, 2'd2);
        read_burst(4'h2, `REG_HEIGHT_WIDTH, 8'd0, 2'd3);

        test_name = "status_backpressure";
        @(negedge clk);
        status.frame_save_num = next_random();
        status.frame_notready = seed[20];
        status.frame_height_width = next_random();
        status.frame_de_num = next_random();
        status.total_need_frame_num = next_random();
        read_burst(4'he, `REG_NEED_FRAME, 8'd5, `BURST_INCR);

        repeat (2) @(negedge clk);
        if (exp_r_addr.size() != 0 || exp_b_id.size() != 0) begin
            $display("run ended with read beats or write responses still outstanding");
            stop_with_failure();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+source
source/capture_pkg.sv
source/slave_channel_fsm.sv
source/burst_addr_gen.sv
source/capture_regs.sv
source/reg_read_mux.sv
source/capture_ctrl_slave.sv
verif/tb_capture_ctrl_slave.sv
